// ==== all.f ====
sipo_pkg.sv
srl.sv
frame_sequencer.sv
sipo_y.sv
pe_array.sv
sipo_top.sv
sipo_top_sva.sv
tb_sipo_top.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the tap distribution testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module tb_sipo_top -Mdir obj_dir -f all.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

# Keep running after a bound assertion error so the testbench reports it
out=$(./obj_dir/Vtb_sipo_top +verilator+error+limit+100 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qF "*** TEST PASSED ***"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// ==== tb_sipo_top.sv ====
`timescale 1ns/1ps

module tb_sipo_top;

    import sipo_pkg::*;

    localparam int PE_NUM        = PE_NUM_DEF;
    localparam int REG_DEPTH     = REG_DEPTH_DEF;
    localparam int CHAIN_LEN     = PE_NUM * REG_DEPTH;
    localparam int NUM_FRAMES    = 6;
    localparam int RESET_CYCLES  = 8;
    localparam int FRAME_TIMEOUT = 16 * CHAIN_LEN;

    typedef cplx_t [PE_NUM-1:0] tap_vec_t;
    typedef acc_t [PE_NUM-1:0]  sum_vec_t;

    logic     clk;
    logic     arst_n;
    logic     en;
    cplx_t    s_in;
    tap_vec_t taps;
    sum_vec_t sums;
    logic     sums_valid;

    // Stimulus state
    integer seed;
    int     stall_left;

    // Reference model state
    cplx_t    hist [$];    // every sample accepted during load
    logic     load_ph;
    int       ph_cnt;
    int       en_cnt;      // Enabled cycles since the last strobe
    logic     exp_valid;
    logic     exp_pass_end;
    logic     seen_valid;
    tap_vec_t exp_taps;
    acc_t     exp_sum;
    logic     prev_en;
    tap_vec_t prev_taps;
    sum_vec_t prev_sums;

    always #2 clk = ~clk;

    sipo_top #(
        .PE_NUM    (PE_NUM),
        .REG_DEPTH (REG_DEPTH)
    ) dut_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .en         (en),
        .s_in       (s_in),
        .taps       (taps),
        .sums       (sums),
        .sums_valid (sums_valid)
    );

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////

    // Tap k shows the sample loaded (k+1)*REG_DEPTH loads ago
    function automatic tap_vec_t taps_from_history();
        tap_vec_t v;
        int       idx;
        for (int k = 0; k < PE_NUM; k++) begin
            idx = hist.size() - (k + 1) * REG_DEPTH;
            if (idx >= 0) begin
                v[k] = hist[idx];
            end else begin
                v[k] = '0;
            end
        end
        return v;
    endfunction

    // Complex sum of the last chain-length loads
    function automatic acc_t sum_of_last_load();
        int   re_sum;
        int   im_sum;
        acc_t r;
        re_sum = 0;
        im_sum = 0;
        for (int i = hist.size() - CHAIN_LEN; i < hist.size(); i++) begin
            if (i >= 0) begin
                re_sum = re_sum + int'(hist[i].re);
                im_sum = im_sum + int'(hist[i].im);
            end
        end
        r.re = ACC_WIDTH'(re_sum);
        r.im = ACC_WIDTH'(im_sum);
        return r;
    endfunction

    // Last enabled cycle of recirculate
    assign exp_pass_end = !load_ph && (ph_cnt == CHAIN_LEN - 1) && en;

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            load_ph    <= 1'b1;
            ph_cnt     <= 0;
            en_cnt     <= 0;
            exp_valid  <= 1'b0;
            seen_valid <= 1'b0;
            exp_taps   <= '0;
            exp_sum    <= '0;
            prev_en    <= 1'b0;
            prev_taps  <= '0;
            prev_sums  <= '0;
        end else begin
            exp_valid <= exp_pass_end;
            prev_en   <= en;
            prev_taps <= taps;
            prev_sums <= sums;
            if (sums_valid) begin
                // Strobe cycle already belongs to the next frame
                seen_valid <= 1'b1;
                en_cnt     <= en ? 1 : 0;
            end else if (en) begin
                en_cnt <= en_cnt + 1;
            end
            if (en) begin
                if (ph_cnt == CHAIN_LEN - 1) begin
                    ph_cnt  <= 0;
                    load_ph <= ~load_ph;
                end else begin
                    ph_cnt <= ph_cnt + 1;
                end
                if (load_ph) begin
                    hist.push_back(s_in);
                    exp_taps <= taps_from_history();
                    exp_sum  <= sum_of_last_load();
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    a_valid: assert property (@(posedge clk) disable iff (!arst_n)
        sums_valid == exp_valid)
    else begin
        $display("Fail at time %0t: sums_valid expected %b, got %b",
                 $time, exp_valid, sums_valid);
        abort_run();
    end

    // Two chain lengths of enabled cycles per frame
    a_rhythm: assert property (@(posedge clk) disable iff (!arst_n)
        sums_valid |-> en_cnt == 2 * CHAIN_LEN)
    else begin
        $display("Fail at time %0t: enabled cycles per frame expected %0d, got %0d",
                 $time, 2 * CHAIN_LEN, en_cnt);
        abort_run();
    end

    // Nothing moves across a disabled cycle
    a_taps_hold: assert property (@(posedge clk) disable iff (!arst_n)
        !prev_en |-> taps == prev_taps)
    else begin
        $display("Fail at time %0t: taps expected %h, got %h", $time, prev_taps, taps);
        abort_run();
    end

    a_sums_hold: assert property (@(posedge clk) disable iff (!arst_n)
        (seen_valid && !prev_en) |-> sums == prev_sums)
    else begin
        $display("Fail at time %0t: sums expected %h, got %h", $time, prev_sums, sums);
        abort_run();
    end

    for (genvar k = 0; k < PE_NUM; k++) begin : g_pe_chk
        // First load cycle after a pass also proves the ring came back intact
        a_tap: assert property (@(posedge clk) disable iff (!arst_n)
            load_ph |-> taps[k] == exp_taps[k])
        else begin
            $display("Fail at time %0t: taps[%0d] expected %h, got %h",
                     $time, k, exp_taps[k], taps[k]);
            abort_run();
        end

        a_sum: assert property (@(posedge clk) disable iff (!arst_n)
            sums_valid |-> sums[k] == exp_sum)
        else begin
            $display("Fail at time %0t: sums[%0d] expected %h, got %h",
                     $time, k, exp_sum, sums[k]);
            abort_run();
        end
    end

    // Bound structural checks raise a flag
    always @(posedge clk) begin
        if (dut_i.u_sipo_top_sva.any_fail) begin
            $display("A structural check inside the DUT failed");
            abort_run();
        end
    end

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    task automatic abort_run();
        $display("*** TEST FAILED ***");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    // New sample every cycle, en low in random stretches
    task automatic drive_inputs(input bit stalls);
        logic [31:0] rnd;
        rnd  = $random(seed);
        s_in = rnd[15:0];
        if (stall_left > 0) begin
            en = 1'b0;
            stall_left--;
        end else if (stalls && rnd[19:17] == 3'd0) begin
            en         = 1'b0;
            stall_left = int'(rnd[23:21]);
        end else begin
            en = 1'b1;
        end
    endtask

    // Runs until the result strobe shows up
    task automatic run_frame(input bit stalls);
        int cyc;
        bit done;
        cyc  = 0;
        done = 1'b0;
        while (!done && cyc < FRAME_TIMEOUT) begin
            @(posedge clk);
            #1;
            done = sums_valid;
            drive_inputs(stalls);
            cyc++;
        end
        if (!done) begin
            $display("Timeout: no result strobe within %0d cycles", FRAME_TIMEOUT);
            abort_run();
        end
    endtask

    initial begin
        seed       = 32'h8723518d;
        stall_left = 0;
        clk        = 1'b0;
        arst_n     = 1'b0;
        en         = 1'b0;
        s_in       = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        arst_n = 1'b1;
        // Odd frames get stalls
        for (int f = 0; f < NUM_FRAMES; f++) begin
            run_frame(f % 2 == 1);
        end
        repeat (2) @(posedge clk);
        #1;
        if (dut_i.u_sipo_top_sva.any_fail) begin
            $display("A structural check inside the DUT failed");
            abort_run();
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

// ==== sipo_top_sva.sv ====
`timescale 1ns/1ps

module sipo_top_sva (
    input logic                clk,
    input logic                arst_n,
    input sipo_pkg::seq_ctrl_t ctrl,
    input logic                sums_valid
);

    // One sticky flag per rule
    bit   double_strobe = 1'b0;
    bit   strobe_align  = 1'b0;
    bit   end_in_load   = 1'b0;
    logic any_fail;

    assign any_fail = double_strobe | strobe_align | end_in_load;

    //////////////////////////////////////////////////
    // Strobe and phase structure
    //////////////////////////////////////////////////

    // Result strobe is one clock wide
    a_single_strobe: assert property (@(posedge clk) disable iff (!arst_n)
        !(sums_valid && $past(sums_valid)))
    else begin
        double_strobe = 1'b1;
        $error("sums_valid high on two consecutive cycles");
    end

    // Strobe trails pass_end by exactly one clock
    a_strobe_align: assert property (@(posedge clk) disable iff (!arst_n)
        sums_valid == $past(ctrl.pass_end))
    else begin
        strobe_align = 1'b1;
        $error("sums_valid does not follow pass_end by one cycle");
    end

    // Pass ends on the last recirculate cycle, load resumes right after
    a_end_in_load: assert property (@(posedge clk) disable iff (!arst_n)
        ctrl.pass_end |-> !ctrl.load ##1 ctrl.load)
    else begin
        end_in_load = 1'b1;
        $error("pass_end raised outside the last recirculate cycle");
    end

endmodule

bind sipo_top sipo_top_sva u_sipo_top_sva (
    .clk        (clk),
    .arst_n     (arst_n),
    .ctrl       (ctrl),
    .sums_valid (sums_valid)
);

// ==== sipo_top.sv ====
`timescale 1ns/1ps

module sipo_top #(
    parameter int PE_NUM    = sipo_pkg::PE_NUM_DEF,
    parameter int REG_DEPTH = sipo_pkg::REG_DEPTH_DEF
) (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         en,
    input  sipo_pkg::cplx_t              s_in,
    output sipo_pkg::cplx_t [PE_NUM-1:0] taps,
    output sipo_pkg::acc_t [PE_NUM-1:0]  sums,
    output logic                         sums_valid
);

    import sipo_pkg::*;

    // Phase control shared by chain and PEs
    seq_ctrl_t ctrl;

    //////////////////////////////////////////////////
    // Producer, buffer, consumer
    //////////////////////////////////////////////////

    frame_sequencer #(
        .PE_NUM    (PE_NUM),
        .REG_DEPTH (REG_DEPTH)
    ) u_frame_sequencer (
        .clk    (clk),
        .arst_n (arst_n),
        .en     (en),
        .ctrl   (ctrl)
    );

    // Tap vector also goes to the top output
    sipo_y #(
        .PE_NUM    (PE_NUM),
        .REG_DEPTH (REG_DEPTH)
    ) u_sipo_y (
        .clk    (clk),
        .arst_n (arst_n),
        .en     (en),
        .ctrl   (ctrl),
        .s_in   (s_in),
        .taps   (taps)
    );

    pe_array #(
        .PE_NUM (PE_NUM)
    ) u_pe_array (
        .clk        (clk),
        .arst_n     (arst_n),
        .en         (en),
        .ctrl       (ctrl),
        .taps       (taps),
        .sums       (sums),
        .sums_valid (sums_valid)
    );

endmodule

// ==== pe_array.sv ====
`timescale 1ns/1ps

module pe_array #(
    parameter int PE_NUM = sipo_pkg::PE_NUM_DEF
) (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        en,
    input  sipo_pkg::seq_ctrl_t         ctrl,
    input  sipo_pkg::cplx_t [PE_NUM-1:0] taps,
    output sipo_pkg::acc_t [PE_NUM-1:0]  sums,
    output logic                        sums_valid
);

    import sipo_pkg::*;

    //////////////////////////////////////////////////
    // Complex helpers
    //////////////////////////////////////////////////

    // Sign-extend a sample to accumulator width
    function automatic acc_t widen(cplx_t s);
        acc_t r;
        r.re = {{(ACC_WIDTH - DATA_WIDTH){s.re[DATA_WIDTH-1]}}, s.re};
        r.im = {{(ACC_WIDTH - DATA_WIDTH){s.im[DATA_WIDTH-1]}}, s.im};
        return r;
    endfunction

    // Part-wise complex add
    function automatic acc_t acc_add(acc_t a, acc_t b);
        acc_t r;
        r.re = a.re + b.re;
        r.im = a.im + b.im;
        return r;
    endfunction

    // Running sums and their next values
    acc_t acc      [PE_NUM];
    acc_t acc_next [PE_NUM];
    logic acc_step;

    // Accumulate only on enabled recirculate cycles
    assign acc_step = en & ~ctrl.load;

    always_comb begin
        for (int i = 0; i < PE_NUM; i++) begin
            acc_next[i] = acc_add(acc[i], widen(taps[i]));
        end
    end

    //////////////////////////////////////////////////
    // Accumulators
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < PE_NUM; i++) begin
                acc[i] <= '0;
            end
        end else if (acc_step) begin
            for (int i = 0; i < PE_NUM; i++) begin
                if (ctrl.pass_end) begin
                    // Start clean for the next pass
                    acc[i] <= '0;
                end else begin
                    acc[i] <= acc_next[i];
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Result latch and strobe
    //////////////////////////////////////////////////

    // Final sum includes the tap of the last cycle
    always_ff @(posedge clk) begin
        if (ctrl.pass_end) begin
            for (int i = 0; i < PE_NUM; i++) begin
                sums[i] <= acc_next[i];
            end
        end
    end

    // pass_end already qualified by en, so one clock wide
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sums_valid <= 1'b0;
        end else begin
            sums_valid <= ctrl.pass_end;
        end
    end

endmodule

// ==== sipo_y.sv ====
`timescale 1ns/1ps

module sipo_y #(
    parameter int PE_NUM    = sipo_pkg::PE_NUM_DEF,
    parameter int REG_DEPTH = sipo_pkg::REG_DEPTH_DEF
) (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         en,
    input  sipo_pkg::seq_ctrl_t          ctrl,
    input  sipo_pkg::cplx_t              s_in,
    output sipo_pkg::cplx_t [PE_NUM-1:0] taps
);

    import sipo_pkg::*;

    // Chain head and per-stage outputs
    cplx_t head;
    cplx_t stage_out [PE_NUM];

    //////////////////////////////////////////////////
    // Head multiplexer
    //////////////////////////////////////////////////

    // Unregistered, keeps sample and phase on the same cycle
    always_comb begin
        if (ctrl.load) begin
            head = s_in;
        end else begin
            // Tail wraps back to the head
            head = stage_out[PE_NUM-1];
        end
    end

    //////////////////////////////////////////////////
    // Stage chain
    //////////////////////////////////////////////////

    for (genvar i = 0; i < PE_NUM; i++) begin : g_stage
        if (i == 0) begin : g_first
            // First stage fed from the head mux
            srl #(
                .DEPTH (REG_DEPTH)
            ) u_srl (
                .clk    (clk),
                .arst_n (arst_n),
                .ce     (en),
                .din    (head),
                .dout   (stage_out[i])
            );
        end else begin : g_next
            // Fed from the previous stage
            srl #(
                .DEPTH (REG_DEPTH)
            ) u_srl (
                .clk    (clk),
                .arst_n (arst_n),
                .ce     (en),
                .din    (stage_out[i-1]),
                .dout   (stage_out[i])
            );
        end
    end

    // One tap per PE, straight from stage registers
    always_comb begin
        for (int i = 0; i < PE_NUM; i++) begin
            taps[i] = stage_out[i];
        end
    end

endmodule

// ==== frame_sequencer.sv ====
`timescale 1ns/1ps

module frame_sequencer #(
    parameter int PE_NUM    = sipo_pkg::PE_NUM_DEF,
    parameter int REG_DEPTH = sipo_pkg::REG_DEPTH_DEF
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                en,
    output sipo_pkg::seq_ctrl_t ctrl
);

    // Counter widths, at least one bit each
    localparam int REG_CNT_W = (REG_DEPTH > 1) ? $clog2(REG_DEPTH) : 1;
    localparam int PE_CNT_W  = (PE_NUM > 1) ? $clog2(PE_NUM) : 1;

    // Terminal counts
    localparam logic [REG_CNT_W-1:0] REG_LAST = REG_CNT_W'(REG_DEPTH - 1);
    localparam logic [PE_CNT_W-1:0]  PE_LAST  = PE_CNT_W'(PE_NUM - 1);

    logic [REG_CNT_W-1:0] reg_cnt;
    logic [PE_CNT_W-1:0]  pe_cnt;
    logic                 recirc;    // 0 load, 1 recirculate
    logic                 reg_wrap;
    logic                 pe_wrap;

    assign reg_wrap = (reg_cnt == REG_LAST);
    assign pe_wrap  = (pe_cnt == PE_LAST);

    //////////////////////////////////////////////////
    // Nested counters and phase bit
    //////////////////////////////////////////////////

    // Inner count runs over stage registers, outer over PEs
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            reg_cnt <= '0;
            pe_cnt  <= '0;
            recirc  <= 1'b0;
        end else if (en) begin
            if (reg_wrap) begin
                reg_cnt <= '0;
                if (pe_wrap) begin
                    // Chain length reached, flip phase
                    pe_cnt <= '0;
                    recirc <= ~recirc;
                end else begin
                    pe_cnt <= pe_cnt + PE_CNT_W'(1);
                end
            end else begin
                reg_cnt <= reg_cnt + REG_CNT_W'(1);
            end
        end
    end

    // Phase outputs
    always_comb begin
        ctrl.load     = ~recirc;
        // Only on an enabled cycle, so a stall holds it off
        ctrl.pass_end = recirc & reg_wrap & pe_wrap & en;
    end

endmodule

// ==== srl.sv ====
`timescale 1ns/1ps

module srl #(
    parameter int DEPTH = sipo_pkg::REG_DEPTH_DEF
) (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            ce,
    input  sipo_pkg::cplx_t din,
    output sipo_pkg::cplx_t dout
);

    import sipo_pkg::*;

    // Delay line, entry 0 newest
    cplx_t sr [DEPTH];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                sr[i] <= '0;
            end
        end else if (ce) begin
            sr[0] <= din;
            // Shift toward the tail
            for (int i = 1; i < DEPTH; i++) begin
                sr[i] <= sr[i-1];
            end
        end
    end

    // Oldest entry
    assign dout = sr[DEPTH-1];

endmodule

// ==== sipo_pkg.sv ====
package sipo_pkg;

    //////////////////////////////////////////////////
    // Sizes
    //////////////////////////////////////////////////

    // Width of each real or imaginary part
    localparam int DATA_WIDTH    = 8;

    // Default PE count, one chain stage per PE
    localparam int PE_NUM_DEF    = 4;

    // Default registers per stage
    localparam int REG_DEPTH_DEF = 4;

    // Six guard bits cover a chain of up to 64 samples
    localparam int ACC_WIDTH     = DATA_WIDTH + 6;

    //////////////////////////////////////////////////
    // Payload and control types
    //////////////////////////////////////////////////

    // Complex input sample
    typedef struct packed {
        logic signed [DATA_WIDTH-1:0] re;
        logic signed [DATA_WIDTH-1:0] im;
    } cplx_t;

    // Complex accumulator, one per PE
    typedef struct packed {
        logic signed [ACC_WIDTH-1:0] re;
        logic signed [ACC_WIDTH-1:0] im;
    } acc_t;

    // Sequencer to chain and PE array
    typedef struct packed {
        logic load;      // High for the whole load phase
        logic pass_end;  // Last enabled recirculate cycle
    } seq_ctrl_t;

endpackage
